//--- include/prbs_consts.svh
`ifndef PRBS_CONSTS_SVH
`define PRBS_CONSTS_SVH

// link and LFSR geometry
`define PRBS_N_CHANNELS 16
`define PRBS_N_PRBS 7
`define PRBS_N_SHIFT_BITS 4
`define PRBS_N_MATCH_BITS 5
`define PRBS_LOCK_COUNT 8

// wishbone widths
`define PRBS_WB_AW 5
`define PRBS_WB_DW 32

// register byte addresses
`define PRBS_REG_CTRL 5'h00
`define PRBS_REG_SEED 5'h04
`define PRBS_REG_STATUS 5'h08
`define PRBS_REG_CORRECT_LO 5'h10
`define PRBS_REG_CORRECT_HI 5'h14
`define PRBS_REG_TOTAL_LO 5'h18
`define PRBS_REG_TOTAL_HI 5'h1C

`endif

//--- design/prbs_pkg.sv
package prbs_pkg;

    // checker operating mode, as written to CTRL[1:0]
    typedef enum logic [1:0] {
        CHK_RESET = 2'b00,
        CHK_ALIGN = 2'b01,
        CHK_TEST  = 2'b10,
        CHK_HOLD  = 2'b11
    } checker_mode_t;

    // read source picked by the bus address
    typedef enum logic [2:0] {
        SEL_CTRL,
        SEL_SEED,
        SEL_STATUS,
        SEL_CORRECT_LO,
        SEL_CORRECT_HI,
        SEL_TOTAL_LO,
        SEL_TOTAL_HI,
        SEL_NONE
    } reg_sel_t;

endpackage

//--- design/prbs_pattern_gen.sv
`timescale 1ns/10ps
`include "prbs_consts.svh"

module prbs_pattern_gen (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        gen_en,
    input  logic [`PRBS_N_PRBS-1:0]     seed,
    input  logic                        inject_err,
    output logic [`PRBS_N_CHANNELS-1:0] tx_bits
);

    logic [`PRBS_N_PRBS-1:0]     state;
    logic [`PRBS_N_PRBS-1:0]     state_next;
    logic [`PRBS_N_CHANNELS-1:0] word;
    logic                        inject_pend;
    logic                        flip;

    // x^7 + x^6 + 1, bit 0 of the word is the earliest bit on the wire
    always_comb begin
        state_next = state;
        for (int i = 0; i < `PRBS_N_CHANNELS; i++) begin
            word[i] = state_next[6] ^ state_next[5];
            state_next = {state_next[`PRBS_N_PRBS-2:0], word[i]};
        end
    end

    // a pulse arriving now or one still waiting flips the next word
    assign flip = inject_err | inject_pend;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= '1;
            tx_bits <= '0;
            inject_pend <= 1'b0;
        end else if (!gen_en) begin
            state <= seed;
            tx_bits <= '0;
            inject_pend <= flip;
        end else begin
            state <= state_next;
            tx_bits <= {word[`PRBS_N_CHANNELS-1:1], word[0] ^ flip};
            inject_pend <= 1'b0;
        end
    end

endmodule

//--- design/prbs_checker_core.sv
`timescale 1ns/10ps
`include "prbs_consts.svh"

module prbs_checker_core (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          cke,
    input  logic [`PRBS_N_PRBS-1:0]       seed,
    input  logic [`PRBS_N_CHANNELS-1:0]   rx_bits,
    input  logic [`PRBS_N_SHIFT_BITS-1:0] rx_shift,
    output logic                          match,
    output logic [`PRBS_N_MATCH_BITS-1:0] match_bits
);

    localparam int match_w = `PRBS_N_MATCH_BITS;

    logic [`PRBS_N_CHANNELS-1:0]   prev_word;
    logic [2*`PRBS_N_CHANNELS-1:0] pair;
    logic [`PRBS_N_CHANNELS-1:0]   window;
    logic [`PRBS_N_CHANNELS-1:0]   ref_word;
    logic [`PRBS_N_CHANNELS-1:0]   eq_bits;
    logic [`PRBS_N_PRBS-1:0]       ref_state;
    logic [`PRBS_N_PRBS-1:0]       ref_next;
    logic [`PRBS_N_MATCH_BITS-1:0] eq_count;

    // older word sits in the low half, so a larger shift looks later in time
    assign pair = {rx_bits, prev_word};
    assign window = pair[rx_shift +: `PRBS_N_CHANNELS];

    // local copy of the transmit sequence
    always_comb begin
        ref_next = ref_state;
        for (int i = 0; i < `PRBS_N_CHANNELS; i++) begin
            ref_word[i] = ref_next[6] ^ ref_next[5];
            ref_next = {ref_next[`PRBS_N_PRBS-2:0], ref_word[i]};
        end
    end

    assign eq_bits = ~(window ^ ref_word);

    always_comb begin
        eq_count = '0;
        for (int i = 0; i < `PRBS_N_CHANNELS; i++) begin
            eq_count = eq_count + match_w'(eq_bits[i]);
        end
    end

    always_ff @(posedge clk) begin
        prev_word <= rx_bits;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ref_state <= seed;
            match <= 1'b0;
            match_bits <= '0;
        end else begin
            // holding the reference for a clock slips it one word behind
            if (cke) begin
                ref_state <= ref_next;
            end
            match <= &eq_bits;
            match_bits <= eq_count;
        end
    end

endmodule

//--- design/prbs_checker.sv
`timescale 1ns/10ps
`include "prbs_consts.svh"

module prbs_checker (
    input  logic                          clk,
    input  logic                          reset,
    input  prbs_pkg::checker_mode_t       mode,
    input  logic [`PRBS_N_PRBS-1:0]       seed,
    input  logic [`PRBS_N_CHANNELS-1:0]   rx_bits,
    output logic [`PRBS_N_SHIFT_BITS-1:0] rx_shift,
    output logic                          locked,
    output logic [63:0]                   correct_bits,
    output logic [63:0]                   total_bits
);

    localparam int shift_w = `PRBS_N_SHIFT_BITS;
    localparam int lock_w = $clog2(`PRBS_LOCK_COUNT + 1);

    logic                          core_rst;
    logic                          core_cke;
    logic                          match;
    logic [`PRBS_N_MATCH_BITS-1:0] match_bits;
    logic [1:0]                    err_count;
    logic [lock_w-1:0]             lock_cnt;

    prbs_checker_core core_i (
        .clk        (clk),
        .reset      (core_rst),
        .cke        (core_cke),
        .seed       (seed),
        .rx_bits    (rx_bits),
        .rx_shift   (rx_shift),
        .match      (match),
        .match_bits (match_bits)
    );

    // saturated count means lock; only a checker reset clears it
    assign locked = (lock_cnt == lock_w'(`PRBS_LOCK_COUNT));

    always_ff @(posedge clk) begin
        if (reset || mode == prbs_pkg::CHK_RESET) begin
            core_rst <= 1'b1;
            core_cke <= 1'b0;
            rx_shift <= '1;
            err_count <= '0;
            lock_cnt <= '0;
            correct_bits <= '0;
            total_bits <= '0;
        end else begin
            core_rst <= 1'b0;
            core_cke <= 1'b1;
            if (!locked) begin
                lock_cnt <= match ? lock_cnt + lock_w'(1) : '0;
            end
            case (mode)
                prbs_pkg::CHK_ALIGN: begin
                    correct_bits <= '0;
                    total_bits <= '0;
                    if (match) begin
                        err_count <= '0;
                    end else if (err_count == 2'd3) begin
                        err_count <= '0;
                        // wrap back to the top and let the data catch up one word
                        if (rx_shift == '0) begin
                            rx_shift <= '1;
                            core_cke <= 1'b0;
                        end else begin
                            rx_shift <= rx_shift - shift_w'(1);
                        end
                    end else begin
                        err_count <= err_count + 2'd1;
                    end
                end
                prbs_pkg::CHK_TEST: begin
                    err_count <= '0;
                    correct_bits <= correct_bits + 64'(match_bits);
                    total_bits <= total_bits + 64'(`PRBS_N_CHANNELS);
                end
                default: begin
                    // hold: the core keeps running, counters stay put
                    err_count <= '0;
                end
            endcase
        end
    end

endmodule

//--- design/prbs_wb_regs.sv
`timescale 1ns/10ps
`include "prbs_consts.svh"

module prbs_wb_regs (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [`PRBS_WB_AW-1:0]        wb_adr,
    input  logic [`PRBS_WB_DW-1:0]        wb_dat_w,
    input  logic [3:0]                    wb_sel,
    output logic [`PRBS_WB_DW-1:0]        wb_dat_r,
    output logic                          wb_ack,
    output prbs_pkg::checker_mode_t       mode,
    output logic                          gen_en,
    output logic [`PRBS_N_PRBS-1:0]       seed,
    output logic                          inject_err,
    input  logic [`PRBS_N_SHIFT_BITS-1:0] rx_shift,
    input  logic                          locked,
    input  logic [63:0]                   correct_bits,
    input  logic [63:0]                   total_bits
);

    prbs_pkg::reg_sel_t      sel;
    logic                    req;
    logic                    wr;
    logic [`PRBS_WB_DW-1:0]  rd_data;

    // the ack term keeps one request from being acked twice
    assign req = wb_cyc & wb_stb & ~wb_ack;
    // only full-word writes are honoured
    assign wr = req & wb_we & (&wb_sel);

    always_comb begin
        case (wb_adr)
            `PRBS_REG_CTRL:       sel = prbs_pkg::SEL_CTRL;
            `PRBS_REG_SEED:       sel = prbs_pkg::SEL_SEED;
            `PRBS_REG_STATUS:     sel = prbs_pkg::SEL_STATUS;
            `PRBS_REG_CORRECT_LO: sel = prbs_pkg::SEL_CORRECT_LO;
            `PRBS_REG_CORRECT_HI: sel = prbs_pkg::SEL_CORRECT_HI;
            `PRBS_REG_TOTAL_LO:   sel = prbs_pkg::SEL_TOTAL_LO;
            `PRBS_REG_TOTAL_HI:   sel = prbs_pkg::SEL_TOTAL_HI;
            default:              sel = prbs_pkg::SEL_NONE;
        endcase
    end

    always_comb begin
        case (sel)
            // inject bit 3 always reads as zero
            prbs_pkg::SEL_CTRL:       rd_data = {{(`PRBS_WB_DW-3){1'b0}}, gen_en, mode};
            prbs_pkg::SEL_SEED:       rd_data = {{(`PRBS_WB_DW-`PRBS_N_PRBS){1'b0}}, seed};
            prbs_pkg::SEL_STATUS:     rd_data = {{(`PRBS_WB_DW-5){1'b0}}, locked, rx_shift};
            prbs_pkg::SEL_CORRECT_LO: rd_data = correct_bits[31:0];
            prbs_pkg::SEL_CORRECT_HI: rd_data = correct_bits[63:32];
            prbs_pkg::SEL_TOTAL_LO:   rd_data = total_bits[31:0];
            prbs_pkg::SEL_TOTAL_HI:   rd_data = total_bits[63:32];
            default:                  rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (req) begin
            wb_dat_r <= rd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
            mode <= prbs_pkg::CHK_RESET;
            gen_en <= 1'b0;
            seed <= 7'h7F;
            inject_err <= 1'b0;
        end else begin
            wb_ack <= req;
            inject_err <= wr && sel == prbs_pkg::SEL_CTRL && wb_dat_w[3];
            if (wr && sel == prbs_pkg::SEL_CTRL) begin
                mode <= prbs_pkg::checker_mode_t'(wb_dat_w[1:0]);
                gen_en <= wb_dat_w[2];
            end
            // a zero seed would lock the LFSR up, so it is dropped
            if (wr && sel == prbs_pkg::SEL_SEED && wb_dat_w[`PRBS_N_PRBS-1:0] != '0) begin
                seed <= wb_dat_w[`PRBS_N_PRBS-1:0];
            end
        end
    end

endmodule

//--- design/prbs_bist_top.sv
`timescale 1ns/10ps
`include "prbs_consts.svh"

module prbs_bist_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  logic [`PRBS_WB_AW-1:0]      wb_adr,
    input  logic [`PRBS_WB_DW-1:0]      wb_dat_w,
    input  logic [3:0]                  wb_sel,
    output logic [`PRBS_WB_DW-1:0]      wb_dat_r,
    output logic                        wb_ack,
    output logic [`PRBS_N_CHANNELS-1:0] tx_bits,
    input  logic [`PRBS_N_CHANNELS-1:0] rx_bits
);

    prbs_pkg::checker_mode_t       mode;
    logic                          gen_en;
    logic                          inject_err;
    logic [`PRBS_N_PRBS-1:0]       seed;
    logic [`PRBS_N_SHIFT_BITS-1:0] rx_shift;
    logic                          locked;
    logic [63:0]                   correct_bits;
    logic [63:0]                   total_bits;

    prbs_wb_regs regs_i (
        .clk          (clk),
        .reset        (reset),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_sel       (wb_sel),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .mode         (mode),
        .gen_en       (gen_en),
        .seed         (seed),
        .inject_err   (inject_err),
        .rx_shift     (rx_shift),
        .locked       (locked),
        .correct_bits (correct_bits),
        .total_bits   (total_bits)
    );

    prbs_pattern_gen gen_i (
        .clk        (clk),
        .reset      (reset),
        .gen_en     (gen_en),
        .seed       (seed),
        .inject_err (inject_err),
        .tx_bits    (tx_bits)
    );

    prbs_checker checker_i (
        .clk          (clk),
        .reset        (reset),
        .mode         (mode),
        .seed         (seed),
        .rx_bits      (rx_bits),
        .rx_shift     (rx_shift),
        .locked       (locked),
        .correct_bits (correct_bits),
        .total_bits   (total_bits)
    );

endmodule

//--- dv/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter real half_period = 20.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // 40 ns period
    always #(half_period) clk = ~clk;

endmodule

//--- dv/prbs_bist_props.sv
`timescale 1ns/10ps
`include "prbs_consts.svh"

module prbs_bist_props (
    input logic                   clk,
    input logic                   reset,
    input logic                   wb_cyc,
    input logic                   wb_stb,
    input logic                   wb_ack,
    input logic [`PRBS_WB_AW-1:0] wb_adr,
    input prbs_pkg::checker_mode_t mode,
    input logic [63:0]            correct_bits,
    input logic [63:0]            total_bits
);

    prbs_pkg::reg_sel_t sel;

    always_comb begin
        case (wb_adr)
            `PRBS_REG_CTRL:       sel = prbs_pkg::SEL_CTRL;
            `PRBS_REG_SEED:       sel = prbs_pkg::SEL_SEED;
            `PRBS_REG_STATUS:     sel = prbs_pkg::SEL_STATUS;
            `PRBS_REG_CORRECT_LO: sel = prbs_pkg::SEL_CORRECT_LO;
            `PRBS_REG_CORRECT_HI: sel = prbs_pkg::SEL_CORRECT_HI;
            `PRBS_REG_TOTAL_LO:   sel = prbs_pkg::SEL_TOTAL_LO;
            `PRBS_REG_TOTAL_HI:   sel = prbs_pkg::SEL_TOTAL_HI;
            default:              sel = prbs_pkg::SEL_NONE;
        endcase
    end

    ack_after_req: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> $past(wb_cyc && wb_stb)) else $error("ack without a request");

    ack_single: assert property (@(posedge clk) disable iff (reset)
        wb_ack |=> !wb_ack) else $error("ack held for more than one cycle");

    total_aligned: assert property (@(posedge clk) disable iff (reset)
        total_bits[3:0] == 4'd0) else $error("total count not a multiple of 16");

    correct_bounded: assert property (@(posedge clk) disable iff (reset)
        correct_bits <= total_bits) else $error("correct count above total count");

    // the checker sees the new mode one clock after the register changes
    hold_frozen: assert property (@(posedge clk) disable iff (reset)
        $past(mode) == prbs_pkg::CHK_HOLD |-> $stable(correct_bits) && $stable(total_bits))
        else $error("counters moved in hold mode");

    unmapped_read: cover property (@(posedge clk) disable iff (reset)
        wb_cyc && wb_stb && sel == prbs_pkg::SEL_NONE);

endmodule

bind prbs_bist_top prbs_bist_props props_i (
    .clk          (clk),
    .reset        (reset),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_ack       (wb_ack),
    .wb_adr       (wb_adr),
    .mode         (mode),
    .correct_bits (correct_bits),
    .total_bits   (total_bits)
);

//--- dv/prbs_bist_tb.sv
`timescale 1ns/10ps
`include "prbs_consts.svh"

module prbs_bist_tb;

    localparam int link_delay = 21;
    localparam int max_cycles = 4000;
    localparam int lock_limit = 600;
    localparam int n_inject = 5;

    logic                        clk;
    logic                        reset;
    logic                        wb_cyc;
    logic                        wb_stb;
    logic                        wb_we;
    logic [`PRBS_WB_AW-1:0]      wb_adr;
    logic [`PRBS_WB_DW-1:0]      wb_dat_w;
    logic [3:0]                  wb_sel;
    logic [`PRBS_WB_DW-1:0]      wb_dat_r;
    logic                        wb_ack;
    logic [`PRBS_N_CHANNELS-1:0] tx_bits;
    logic [`PRBS_N_CHANNELS-1:0] rx_bits;

    logic [31:0] hist;
    logic [47:0] stream;
    int          cycles;
    integer      seed;

    tb_clock_gen clk_i (
        .clk (clk)
    );

    prbs_bist_top dut_i (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .tx_bits  (tx_bits),
        .rx_bits  (rx_bits)
    );

    // loopback channel, newest word on top, so rx bit i is the stream bit 21 places earlier
    always @(negedge clk) begin
        stream = {tx_bits, hist};
        rx_bits <= stream[32-link_delay +: `PRBS_N_CHANNELS];
        hist <= {tx_bits, hist[31:16]};
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: the run went past %0d cycles", max_cycles);
            $display("Simulation FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (act == exp) else begin
            $display("MISMATCH %s expected 0x%0h actual 0x%0h", name, exp, act);
            $display("Simulation FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic check_true(input string name, input bit cond, input string what);
        assert (cond) else begin
            $display("%s: %s", name, what);
            $display("Simulation FAILED");
            $fatal(1, "check failed");
        end
    endtask

    // one bus access; the slave has a few cycles to answer
    task automatic bus_access(input logic we, input logic [`PRBS_WB_AW-1:0] adr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited = 0;
        @(negedge clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_w = wdata;
        wb_sel = 4'hF;
        do begin
            @(negedge clk);
            waited++;
            check_true("bus", waited <= 8, "no ack from the register block");
        end while (!wb_ack);
        rdata = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic wb_write(input logic [`PRBS_WB_AW-1:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [`PRBS_WB_AW-1:0] adr, output logic [31:0] data);
        bus_access(1'b0, adr, 32'h0, data);
    endtask

    task automatic read_counter(input logic [`PRBS_WB_AW-1:0] lo_adr,
                                input logic [`PRBS_WB_AW-1:0] hi_adr,
                                output logic [63:0] value);
        logic [31:0] lo;
        logic [31:0] hi;
        wb_read(lo_adr, lo);
        wb_read(hi_adr, hi);
        value = {hi, lo};
    endtask

    // CTRL word: mode in [1:0], generator enable in bit 2, inject in bit 3
    function automatic logic [31:0] ctrl_word(input logic [1:0] mode, input bit en,
                                              input bit inj);
        return {28'h0, inj, en, mode};
    endfunction

    task automatic wait_for_lock(input string name);
        logic [31:0] status;
        int start;
        start = cycles;
        do begin
            wb_read(`PRBS_REG_STATUS, status);
            check_true(name, cycles - start <= lock_limit, "checker did not lock in time");
        end while (!status[4]);
    endtask

    // transmit words must keep x^7 + x^6 + 1 running across word boundaries
    task automatic scan_tx_words(input string name, input int n_words);
        logic [31:0] last_two;
        logic        exp_bit;
        last_two = '0;
        for (int w = 0; w < n_words; w++) begin
            @(negedge clk);
            last_two = {tx_bits, last_two[31:16]};
            check_true(name, tx_bits != '0, "transmit word is all zeros");
            if (w > 0) begin
                for (int i = `PRBS_N_CHANNELS; i < 32; i++) begin
                    exp_bit = last_two[i-6] ^ last_two[i-7];
                    check_eq(name, 64'(exp_bit), 64'(last_two[i]));
                end
            end
        end
    endtask

    initial begin
        logic [31:0] rd;
        logic [63:0] correct;
        logic [63:0] total;
        logic [63:0] correct2;
        logic [63:0] total2;
        int gap;
        int t_test;
        logic [63:0] exp_total;

        reset = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        wb_sel = '0;
        rx_bits = '0;
        hist = '0;
        cycles = 0;
        seed = 24;

        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // reset values; the checker reset leaves rx_shift at all ones
        wb_read(`PRBS_REG_STATUS, rd);
        check_eq("reset_status", 64'h0F, rd);
        wb_read(`PRBS_REG_CTRL, rd);
        check_eq("reset_ctrl", 64'h0, rd);
        wb_read(`PRBS_REG_SEED, rd);
        check_eq("reset_seed", 64'h7F, rd);
        read_counter(`PRBS_REG_CORRECT_LO, `PRBS_REG_CORRECT_HI, correct);
        check_eq("reset_correct", 64'h0, correct);
        read_counter(`PRBS_REG_TOTAL_LO, `PRBS_REG_TOTAL_HI, total);
        check_eq("reset_total", 64'h0, total);
        wb_read(5'h0C, rd);
        check_eq("unmapped_read", 64'h0, rd);

        // alignment
        wb_write(`PRBS_REG_SEED, 32'h35);
        wb_read(`PRBS_REG_SEED, rd);
        check_eq("seed_write", 64'h35, rd);
        wb_write(`PRBS_REG_CTRL, ctrl_word(2'b01, 1'b1, 1'b0));
        wait_for_lock("align");

        // error free count
        wb_write(`PRBS_REG_CTRL, ctrl_word(2'b10, 1'b1, 1'b0));
        t_test = cycles;
        scan_tx_words("tx_prbs7", 60);
        wb_write(`PRBS_REG_CTRL, ctrl_word(2'b11, 1'b1, 1'b0));
        // one word of 16 bits is counted for every clock spent in test mode
        exp_total = 64'(cycles - t_test) * 64'd16;
        repeat (2) @(negedge clk);
        read_counter(`PRBS_REG_CORRECT_LO, `PRBS_REG_CORRECT_HI, correct);
        read_counter(`PRBS_REG_TOTAL_LO, `PRBS_REG_TOTAL_HI, total);
        check_eq("clean_total_exact", exp_total, total);
        check_eq("clean_correct", exp_total, correct);
        check_eq("clean_total_mod16", 64'h0, total % 16);
        check_true("clean_total", total != 0, "total count stayed at zero in test mode");
        read_counter(`PRBS_REG_CORRECT_LO, `PRBS_REG_CORRECT_HI, correct2);
        read_counter(`PRBS_REG_TOTAL_LO, `PRBS_REG_TOTAL_HI, total2);
        check_eq("hold_correct", exp_total, correct2);
        check_eq("hold_total", exp_total, total2);

        // injected errors after a fresh alignment
        wb_write(`PRBS_REG_CTRL, ctrl_word(2'b00, 1'b1, 1'b0));
        wb_write(`PRBS_REG_CTRL, ctrl_word(2'b01, 1'b1, 1'b0));
        wait_for_lock("realign");
        wb_write(`PRBS_REG_CTRL, ctrl_word(2'b10, 1'b1, 1'b0));
        for (int k = 0; k < n_inject; k++) begin
            gap = 3 + ($unsigned($random(seed)) % 16);
            repeat (gap) @(negedge clk);
            wb_write(`PRBS_REG_CTRL, ctrl_word(2'b10, 1'b1, 1'b1));
        end
        // let the last flipped word cross the channel
        repeat (10) @(negedge clk);
        wb_write(`PRBS_REG_CTRL, ctrl_word(2'b11, 1'b1, 1'b0));
        repeat (2) @(negedge clk);
        read_counter(`PRBS_REG_CORRECT_LO, `PRBS_REG_CORRECT_HI, correct);
        read_counter(`PRBS_REG_TOTAL_LO, `PRBS_REG_TOTAL_HI, total);
        check_eq("inject_errors", 64'(n_inject), total - correct);

        // reset by mode
        wb_write(`PRBS_REG_CTRL, ctrl_word(2'b00, 1'b1, 1'b0));
        repeat (2) @(negedge clk);
        wb_read(`PRBS_REG_STATUS, rd);
        check_eq("mode_reset_locked", 64'h0, rd[4]);
        read_counter(`PRBS_REG_CORRECT_LO, `PRBS_REG_CORRECT_HI, correct);
        check_eq("mode_reset_correct", 64'h0, correct);
        read_counter(`PRBS_REG_TOTAL_LO, `PRBS_REG_TOTAL_HI, total);
        check_eq("mode_reset_total", 64'h0, total);
        wb_write(`PRBS_REG_CTRL, ctrl_word(2'b00, 1'b1, 1'b1));
        wb_read(`PRBS_REG_CTRL, rd);
        check_eq("ctrl_inject_bit", 64'h0, rd[3]);
        check_eq("ctrl_readback", 64'h4, rd);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+include
design/prbs_pkg.sv
design/prbs_pattern_gen.sv
design/prbs_checker_core.sv
design/prbs_checker.sv
design/prbs_wb_regs.sv
design/prbs_bist_top.sv
dv/tb_clock_gen.sv
dv/prbs_bist_props.sv
dv/prbs_bist_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := prbs_bist_tb
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FLAGS      := --timing --assert -f $(FILELIST) --top-module $(TOP)
BUILD_FLAGS := --binary -j 0 --Mdir $(OBJ_DIR)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) $(FLAGS)

run: build
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "run failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "Simulation PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only $(FLAGS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
